//--- verilog/hex_bus_pkg.sv
package hex_bus_pkg;

  // ------------------------------------------------------------
  // Write bus widths
  // ------------------------------------------------------------
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  // Address bit that separates the number word from the control word
  localparam int unsigned WORD_NUMBER_BIT = 3;

  // Byte lanes of the control word
  localparam int unsigned LANE_ENABLE = 0; // Low nibble is the digit enable mask
  localparam int unsigned LANE_SELECT = 1; // Blink selection, 0..3 or none
  localparam int unsigned LANE_CLEAR  = 2; // Any nonzero byte clears everything

endpackage

//--- verilog/hex_disp_pkg.sv
package hex_disp_pkg;

  localparam int unsigned NUM_DIGITS = 4;

  // ------------------------------------------------------------
  // Display-side widths
  // ------------------------------------------------------------
  typedef logic [3:0]            nibble_t;
  typedef logic [15:0]           number_t;     // Digit 0 in the low nibble
  typedef logic [NUM_DIGITS-1:0] digit_mask_t;
  typedef logic [7:0]            select_t;     // Values above 3 mean no blink
  typedef logic [6:0]            seg_t;        // g..a, active low
  typedef logic [NUM_DIGITS-1:0] anode_t;      // Active low
  typedef logic [1:0]            digit_idx_t;

  // ------------------------------------------------------------
  // Block-to-block bundles
  // ------------------------------------------------------------
  typedef struct packed {
    number_t     number;
    digit_mask_t enable;
    select_t     select;
  } disp_cfg_t;

  typedef struct packed {
    number_t     number;
    digit_mask_t lit;   // Digits whose anode may go low this cycle
  } shown_t;

endpackage

//--- verilog/hex_regs.sv
`timescale 1ns/1ps

module hex_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  hex_bus_pkg::bus_data_t  wdata_i,
  input  hex_bus_pkg::bus_addr_t  addr_i,
  input  hex_bus_pkg::bus_be_t    be_i,
  input  logic                    we_i,

  output hex_disp_pkg::disp_cfg_t cfg_o
);

  localparam int unsigned LANE_W = 8;
  localparam int unsigned NIB_W  = $bits(hex_disp_pkg::nibble_t);
  localparam int unsigned MASK_W = $bits(hex_disp_pkg::digit_mask_t);

  // Same values after hard reset and after a clear command
  localparam hex_disp_pkg::disp_cfg_t CLEAR_CFG = '{
    number: '0,
    enable: '1,
    select: 8'hFF
  };

  logic                     word_ctrl;
  logic                     wr_number;
  logic                     wr_ctrl;
  logic [LANE_W-1:0]        enable_byte;
  logic [LANE_W-1:0]        select_byte;
  logic [LANE_W-1:0]        clear_byte;
  logic                     clear_req;

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------
  assign word_ctrl = addr_i[hex_bus_pkg::WORD_NUMBER_BIT];
  assign wr_number = we_i && !word_ctrl;
  assign wr_ctrl   = we_i && word_ctrl;

  assign enable_byte = wdata_i[hex_bus_pkg::LANE_ENABLE*LANE_W +: LANE_W];
  assign select_byte = wdata_i[hex_bus_pkg::LANE_SELECT*LANE_W +: LANE_W];
  assign clear_byte  = wdata_i[hex_bus_pkg::LANE_CLEAR*LANE_W +: LANE_W];

  assign clear_req = wr_ctrl && be_i[hex_bus_pkg::LANE_CLEAR] && (clear_byte != '0);

  // ------------------------------------------------------------
  // Configuration register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cfg_o <= CLEAR_CFG;
    end else if (clear_req) begin
      cfg_o <= CLEAR_CFG; // Wins over lanes 0 and 1 of the same write
    end else begin
      // One byte enable per nibble on the number word
      for (int i = 0; i < hex_disp_pkg::NUM_DIGITS; i++) begin
        if (wr_number && be_i[i]) begin
          cfg_o.number[i*NIB_W +: NIB_W] <= wdata_i[i*NIB_W +: NIB_W];
        end
      end

      if (wr_ctrl && be_i[hex_bus_pkg::LANE_ENABLE]) begin
        cfg_o.enable <= enable_byte[MASK_W-1:0];
      end

      if (wr_ctrl && be_i[hex_bus_pkg::LANE_SELECT]) begin
        cfg_o.select <= select_byte;
      end
    end
  end

endmodule

//--- verilog/hex_blink_timer.sv
`timescale 1ns/1ps

module hex_blink_timer #(
  parameter int unsigned BLINK_HALF = 50_000_000, // Cycles per blink phase, at least 2
  parameter int unsigned SCAN_DIV   = 100_000     // Cycles per scan step, at least 2
) (
  input  logic clk_i,
  input  logic rst_i,

  output logic blink_on_o,
  output logic scan_tick_o
);

  localparam int unsigned BLINK_W = $clog2(BLINK_HALF);
  localparam int unsigned SCAN_W  = $clog2(SCAN_DIV);

  localparam logic [BLINK_W-1:0] BLINK_RELOAD = BLINK_W'(BLINK_HALF - 1);
  localparam logic [SCAN_W-1:0]  SCAN_RELOAD  = SCAN_W'(SCAN_DIV - 1);

  logic [BLINK_W-1:0] blink_cnt;
  logic [SCAN_W-1:0]  scan_cnt;

  // ------------------------------------------------------------
  // Blink phase, toggles every BLINK_HALF cycles
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      blink_cnt  <= BLINK_RELOAD;
      blink_on_o <= 1'b1; // Start in the visible phase
    end else if (blink_cnt == '0) begin
      blink_cnt  <= BLINK_RELOAD;
      blink_on_o <= ~blink_on_o;
    end else begin
      blink_cnt  <= blink_cnt - 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Scan tick, one-cycle pulse every SCAN_DIV cycles
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      scan_cnt    <= SCAN_RELOAD;
      scan_tick_o <= 1'b0;
    end else begin
      scan_tick_o <= (scan_cnt == '0);
      scan_cnt    <= (scan_cnt == '0) ? SCAN_RELOAD : scan_cnt - 1'b1;
    end
  end

endmodule

//--- verilog/hex_digit_compose.sv
`timescale 1ns/1ps

module hex_digit_compose (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  hex_disp_pkg::disp_cfg_t cfg_i,
  input  logic                    blink_on_i,

  output hex_disp_pkg::shown_t    shown_o
);

  hex_disp_pkg::digit_mask_t lit_d;

  // ------------------------------------------------------------
  // Lit mask
  // ------------------------------------------------------------
  // The selected digit follows the blink phase regardless of its enable bit.
  // A selection above 3 matches no digit, so only the enable mask counts.
  always_comb begin
    for (int i = 0; i < hex_disp_pkg::NUM_DIGITS; i++) begin
      if (cfg_i.select == hex_disp_pkg::select_t'(i)) begin
        lit_d[i] = blink_on_i;
      end else begin
        lit_d[i] = cfg_i.enable[i];
      end
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      shown_o.number <= '0;
      shown_o.lit    <= '1; // All digits on, as after a clear
    end else begin
      shown_o.number <= cfg_i.number; // Kept in step with the lit mask
      shown_o.lit    <= lit_d;
    end
  end

endmodule

//--- verilog/hex_seg_scan.sv
`timescale 1ns/1ps

module hex_seg_scan (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  hex_disp_pkg::shown_t   shown_i,
  input  logic                   scan_tick_i,

  output hex_disp_pkg::seg_t     seg_o,
  output hex_disp_pkg::anode_t   an_o
);

  localparam int unsigned NIB_W = $bits(hex_disp_pkg::nibble_t);

  hex_disp_pkg::digit_idx_t idx_q;
  hex_disp_pkg::digit_idx_t idx_next;
  hex_disp_pkg::nibble_t    nib_next;
  hex_disp_pkg::anode_t     an_next;

  // ------------------------------------------------------------
  // Hex to segment decode
  // ------------------------------------------------------------
  function automatic hex_disp_pkg::seg_t seg_decode(input hex_disp_pkg::nibble_t nib);
    case (nib)
      4'h0:    seg_decode = 7'h40;
      4'h1:    seg_decode = 7'h79;
      4'h2:    seg_decode = 7'h24;
      4'h3:    seg_decode = 7'h30;
      4'h4:    seg_decode = 7'h19;
      4'h5:    seg_decode = 7'h12;
      4'h6:    seg_decode = 7'h02;
      4'h7:    seg_decode = 7'h78;
      4'h8:    seg_decode = 7'h00;
      4'h9:    seg_decode = 7'h10;
      4'hA:    seg_decode = 7'h08;
      4'hB:    seg_decode = 7'h03; // Lower case b
      4'hC:    seg_decode = 7'h46;
      4'hD:    seg_decode = 7'h21; // Lower case d
      4'hE:    seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Next digit
  // ------------------------------------------------------------
  assign idx_next = idx_q + 1'b1; // Wraps after digit 3
  assign nib_next = shown_i.number[int'(idx_next)*NIB_W +: NIB_W];

  // Dark digits keep every anode high
  assign an_next = shown_i.lit[idx_next] ? ~(hex_disp_pkg::anode_t'(1) << idx_next) : '1;

  // ------------------------------------------------------------
  // Scan registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      idx_q <= '0;
      an_o  <= '1;
      seg_o <= '1;
    end else if (scan_tick_i) begin
      idx_q <= idx_next;
      an_o  <= an_next;
      seg_o <= seg_decode(nib_next);
    end
  end

endmodule

//--- verilog/hex_display.sv
`timescale 1ns/1ps

module hex_display #(
  parameter int unsigned BLINK_HALF = 50_000_000, // Half blink period at 100 MHz
  parameter int unsigned SCAN_DIV   = 100_000     // 1 ms per digit
) (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  hex_bus_pkg::bus_data_t wdata_i,
  input  hex_bus_pkg::bus_addr_t addr_i,
  input  hex_bus_pkg::bus_be_t   be_i,
  input  logic                   we_i,

  output hex_disp_pkg::seg_t     seg_o,
  output hex_disp_pkg::anode_t   an_o
);

  hex_disp_pkg::disp_cfg_t cfg;
  hex_disp_pkg::shown_t    shown;
  logic                    blink_on;
  logic                    scan_tick;

  hex_regs i_hex_regs (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wdata_i (wdata_i),
    .addr_i  (addr_i),
    .be_i    (be_i),
    .we_i    (we_i),
    .cfg_o   (cfg)
  );

  hex_blink_timer #(
    .BLINK_HALF (BLINK_HALF),
    .SCAN_DIV   (SCAN_DIV)
  ) i_hex_blink_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .blink_on_o  (blink_on),
    .scan_tick_o (scan_tick)
  );

  hex_digit_compose i_hex_digit_compose (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_i      (cfg),
    .blink_on_i (blink_on),
    .shown_o    (shown)
  );

  hex_seg_scan i_hex_seg_scan (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .shown_i     (shown),
    .scan_tick_i (scan_tick),
    .seg_o       (seg_o),
    .an_o        (an_o)
  );

endmodule

//--- test/hex_clk_gen.sv
`timescale 1ns/1ps

module hex_clk_gen #(
  parameter int unsigned PERIOD_NS  = 8,
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0; // Released away from the active edge
  end

endmodule

//--- test/hex_display_chk.sv
`timescale 1ns/1ps

module hex_display_chk (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 scan_tick_i,
  input hex_disp_pkg::seg_t   seg_i,
  input hex_disp_pkg::anode_t an_i
);

  logic tick_seen;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tick_seen <= 1'b0;
    end else if (scan_tick_i) begin
      tick_seen <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Scan output rules
  // ------------------------------------------------------------
  one_anode_low: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(~an_i))
    else $error("more than one anode driven low: %b", an_i);

  // Outputs only move on the edge that samples a tick
  steady_between_ticks: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(scan_tick_i) |-> ($stable(an_i) && $stable(seg_i)))
    else $error("an_o or seg_o changed without a scan tick");

  dark_until_first_tick: assert property (@(posedge clk_i) disable iff (rst_i)
    !tick_seen |-> (an_i == '1))
    else $error("anode driven low before the first scan tick");

endmodule

bind hex_display hex_display_chk i_hex_display_chk (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .scan_tick_i (scan_tick),
  .seg_i       (seg_o),
  .an_i        (an_o)
);

//--- test/hex_display_tb.sv
`timescale 1ns/1ps

module hex_display_tb;

  localparam int unsigned BLINK_HALF = 40;
  localparam int unsigned SCAN_DIV   = 3;
  localparam int unsigned WIN        = 8 * SCAN_DIV; // Two full scans

  logic                   clk;
  logic                   rst;
  hex_bus_pkg::bus_data_t wdata;
  hex_bus_pkg::bus_addr_t addr;
  hex_bus_pkg::bus_be_t   be;
  logic                   we;
  hex_disp_pkg::seg_t     seg;
  hex_disp_pkg::anode_t   an;

  hex_disp_pkg::disp_cfg_t exp_cfg; // Model of the register bank
  int unsigned             cyc;     // Edges since reset release

  hex_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(10)) i_hex_clk_gen (.clk_o(clk), .rst_o(rst));

  hex_display #(
    .BLINK_HALF (BLINK_HALF),
    .SCAN_DIV   (SCAN_DIV)
  ) i_hex_display (
    .clk_i   (clk),
    .rst_i   (rst),
    .wdata_i (wdata),
    .addr_i  (addr),
    .be_i    (be),
    .we_i    (we),
    .seg_o   (seg),
    .an_o    (an)
  );

  always @(posedge clk or posedge rst) begin
    if (rst) cyc <= 0;
    else     cyc <= cyc + 1;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic hex_disp_pkg::disp_cfg_t ref_write(input hex_disp_pkg::disp_cfg_t cur,
      input hex_bus_pkg::bus_addr_t a, input hex_bus_pkg::bus_data_t d,
      input hex_bus_pkg::bus_be_t b);
    hex_disp_pkg::disp_cfg_t nxt;
    nxt = cur;
    if (!a[hex_bus_pkg::WORD_NUMBER_BIT]) begin
      for (int n = 0; n < 4; n++) begin
        if (b[n]) nxt.number[4*n +: 4] = d[4*n +: 4];
      end
    end else if (b[hex_bus_pkg::LANE_CLEAR] && d[23:16] != 8'h00) begin
      nxt = '{16'h0000, 4'hF, 8'hFF}; // Clear beats lanes 0 and 1
    end else begin
      if (b[hex_bus_pkg::LANE_ENABLE]) nxt.enable = d[3:0];
      if (b[hex_bus_pkg::LANE_SELECT]) nxt.select = d[15:8];
    end
    return nxt;
  endfunction

  function automatic hex_disp_pkg::digit_mask_t ref_lit(input hex_disp_pkg::disp_cfg_t c,
      input logic blink);
    hex_disp_pkg::digit_mask_t lit;
    lit = c.enable;
    if (c.select < 4) lit[c.select[1:0]] = blink; // Selected digit follows the phase
    return lit;
  endfunction

  function automatic hex_disp_pkg::seg_t ref_seg(input hex_disp_pkg::nibble_t nib);
    hex_disp_pkg::seg_t table_g2a [16];
    table_g2a = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
                  7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
                  7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
                  7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110};
    return table_g2a[nib];
  endfunction

  // ------------------------------------------------------------
  // Failure reporting and compares
  // ------------------------------------------------------------
  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "Stopping at first failure");
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out at cycle %0d while waiting for %s", cyc, what);
    stop_with_failure();
  endtask

  task automatic check_seg(input string name, input hex_disp_pkg::seg_t got,
      input hex_disp_pkg::seg_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cyc);
      stop_with_failure();
    end
  endtask

  task automatic check_an(input string name, input hex_disp_pkg::anode_t got,
      input hex_disp_pkg::anode_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cyc);
      stop_with_failure();
    end
  endtask

  // ------------------------------------------------------------
  // Bus driver and waits
  // ------------------------------------------------------------
  task automatic bus_write(input hex_bus_pkg::bus_addr_t a, input hex_bus_pkg::bus_data_t d,
      input hex_bus_pkg::bus_be_t b);
    @(negedge clk);
    addr  = a;
    wdata = d;
    be    = b;
    we    = 1'b1;
    @(negedge clk);
    we    = 1'b0;
    exp_cfg = ref_write(exp_cfg, a, d, b);
  endtask

  task automatic ctrl_write(input logic [7:0] clr, input logic [7:0] sel,
      input logic [3:0] en, input hex_bus_pkg::bus_be_t b);
    bus_write($urandom | 32'h8, {8'h00, clr, sel, 4'h0, en}, b);
  endtask

  // Register, compose and one scan step
  task automatic settle();
    repeat (SCAN_DIV + 3) @(negedge clk);
  endtask

  task automatic wait_until_cycle(input int unsigned target);
    int unsigned n;
    n = 0;
    while (cyc < target) begin
      @(negedge clk);
      n++;
      if (n > 4 * BLINK_HALF + 100) fail_timeout("a blink window");
    end
  endtask

  // Middle of the next phase where blink_on equals want_on
  task automatic wait_phase_window(input logic want_on);
    int unsigned p;
    p = cyc / BLINK_HALF + 1;
    if (((p % 2) == 0) != want_on) p++;
    wait_until_cycle(p * BLINK_HALF + (BLINK_HALF - WIN) / 2);
  endtask

  task automatic wait_anode_low();
    int unsigned n;
    n = 0;
    while (an == '1) begin
      @(negedge clk);
      n++;
      if (n > 2 * WIN) fail_timeout("an anode to go low");
    end
  endtask

  // ------------------------------------------------------------
  // Scan sampler
  // ------------------------------------------------------------
  task automatic observe_scan(input logic blink);
    hex_disp_pkg::anode_t      seen;
    hex_disp_pkg::digit_mask_t lit;
    int                        d;
    seen = '1;
    lit  = ref_lit(exp_cfg, blink);
    repeat (WIN) begin
      @(negedge clk);
      if (an != '1) begin
        d = 0;
        for (int i = 0; i < 4; i++) begin
          if (!an[i]) d = i;
        end
        check_seg($sformatf("seg_o[digit %0d]", d), seg, ref_seg(exp_cfg.number[4*d +: 4]));
      end
      seen &= an; // Low bit marks a digit seen lit
    end
    check_an("an_o", seen, ~lit);
  endtask

  task automatic check_both_phases();
    wait_phase_window(1'b1);
    observe_scan(1'b1);
    wait_phase_window(1'b0);
    observe_scan(1'b0);
  endtask

  initial begin
    logic [7:0] sel;
    void'($urandom(32'hbfa4));
    wdata   = '0;
    addr    = '0;
    be      = '0;
    we      = 1'b0;
    exp_cfg = '{16'h0000, 4'hF, 8'hFF};

    for (int n = 0; rst !== 1'b0; n++) begin
      @(negedge clk);
      if (n > 100) fail_timeout("reset release");
    end

    // After reset all four digits show 0
    wait_anode_low();
    observe_scan(1'b1);

    // Number writes with random byte enables
    repeat (8) begin
      bus_write($urandom & ~32'h8, $urandom, 4'($urandom));
      settle();
      if (exp_cfg.enable != 0) wait_anode_low();
      observe_scan(1'b1);
    end

    // Enable mask with no blink selected
    repeat (6) begin
      ctrl_write(8'($urandom), 8'($urandom), 4'($urandom), 4'b0001);
      settle();
      if (exp_cfg.enable != 0) wait_anode_low();
      observe_scan(1'b1);
    end

    // Blink one digit
    repeat (4) begin
      ctrl_write(8'h00, 8'($urandom % 4), 4'($urandom), 4'b0011);
      settle();
      check_both_phases();
    end
    sel = 8'd4 + 8'($urandom % 252);
    ctrl_write(8'h00, sel, 4'b1010, 4'b0011);
    settle();
    check_both_phases();

    // Zero clear byte leaves lanes 0 and 1 in effect
    ctrl_write(8'h00, 8'h02, 4'h5, 4'b0111);
    bus_write(32'h0, $urandom, 4'hF);
    settle();
    check_both_phases();

    // Clear with lanes 0 and 1 in the same write
    ctrl_write(8'($urandom | 1), 8'h01, 4'h0, 4'b0111);
    settle();
    check_both_phases();

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- hex_display.f
verilog/hex_bus_pkg.sv
verilog/hex_disp_pkg.sv
verilog/hex_regs.sv
verilog/hex_blink_timer.sv
verilog/hex_digit_compose.sv
verilog/hex_seg_scan.sv
verilog/hex_display.sv
test/hex_clk_gen.sv
test/hex_display_chk.sv
test/hex_display_tb.sv
